/* build.f */
common/cpu_cfg_pkg.sv
common/decinfo_pkg.sv
hdu/hdu.sv
wbu/gpr.sv
wbu/wbu.sv
source/cpu_backend.sv
sim/tb_cpu_backend.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench into sim.log and check it"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module tb_cpu_backend -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_cpu_backend.sv */
module tb_cpu_backend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LONG_IDS = 4;
    localparam int ID_W = $clog2(LONG_IDS);
    localparam int AW = cpu_cfg_pkg::REG_ADDR_WIDTH;
    localparam int DW = cpu_cfg_pkg::REG_DATA_WIDTH;
    localparam int N_TESTS = 5;
    localparam int CYCLES_PER_TEST = 400;

    logic clk, rst_n_i;
    logic issue_valid_i, issue_rd_we_i, hazard_stall_o, atom_busy_o;
    logic [decinfo_pkg::DECINFO_WIDTH-1:0] issue_dec_info_i;
    logic [AW-1:0] issue_rd_i, issue_rs1_i, issue_rs2_i;
    logic [ID_W-1:0] issue_id_o, muldiv_id_i, agu_id_i;
    logic alu_we_i, muldiv_we_i, agu_we_i;
    logic alu_ready_o, muldiv_ready_o, agu_ready_o;
    logic [AW-1:0] alu_waddr_i, muldiv_waddr_i, agu_waddr_i, raddr1_i, raddr2_i;
    logic [DW-1:0] alu_wdata_i, muldiv_wdata_i, agu_wdata_i, rdata1_o, rdata2_o;

    // expected register contents and IDs still in flight
    logic [DW-1:0] model_regs [cpu_cfg_pkg::REG_NUM];
    logic [LONG_IDS-1:0] model_busy;
    int err_count, err_mark, n_tests, n_failed;

    cpu_backend #(.LONG_IDS(LONG_IDS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (N_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", N_TESTS * CYCLES_PER_TEST);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_data(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] got,
                            input logic [ID_W-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (err_count != err_mark) n_failed++;
        $display("test %s: %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    function automatic int lowest_free();
        for (int i = 0; i < LONG_IDS; i++) begin
            if (!model_busy[i]) return i;
        end
        return 0;
    endfunction

    function automatic void model_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        if (addr != '0) model_regs[addr] = data;  // x0 never changes
    endfunction

    // present one instruction and check stall and ID, inputs stay held
    task automatic issue(input logic [decinfo_pkg::DECINFO_GRP_WIDTH-1:0] grp, input logic load,
                         input logic [AW-1:0] rd, input logic [AW-1:0] rs1, input logic stall);
        logic [decinfo_pkg::DECINFO_WIDTH-1:0] info;
        logic is_long;
        int id;
        info = '0;
        info[decinfo_pkg::DECINFO_GRP_LSB +: decinfo_pkg::DECINFO_GRP_WIDTH] = grp;
        info[decinfo_pkg::DECINFO_MEM_OP_LOAD] = load;
        is_long = (grp == decinfo_pkg::DECINFO_GRP_MULDIV) ||
                  ((grp == decinfo_pkg::DECINFO_GRP_MEM) && load);
        @(posedge clk);
        issue_valid_i <= 1'b1;
        issue_dec_info_i <= info;
        issue_rd_i <= rd;
        issue_rd_we_i <= 1'b1;
        issue_rs1_i <= rs1;
        issue_rs2_i <= '0;
        @(negedge clk);
        check_flag("hazard_stall_o", hazard_stall_o, stall);
        if (is_long && !stall) begin
            id = lowest_free();
            check_id("issue_id_o", issue_id_o, ID_W'(id));
            model_busy[id] = 1'b1;  // taken at the coming edge
        end
    endtask

    task automatic release_issue();
        @(posedge clk);
        issue_valid_i <= 1'b0;
    endtask

    // take presented results one per edge, checking ready and read-back
    task automatic drain_writebacks();
        logic [AW-1:0] last_addr;
        logic [AW-1:0] other_addr;
        int src;
        @(negedge clk);
        while (muldiv_we_i || agu_we_i || alu_we_i) begin
            // 0 muldiv, 1 load unit, 2 alu, first one presenting wins
            if (muldiv_we_i) begin
                src = 0;
            end else if (agu_we_i) begin
                src = 1;
            end else begin
                src = 2;
            end
            check_flag("muldiv_ready_o", muldiv_ready_o, 1'b1);
            check_flag("agu_ready_o", agu_ready_o, src == 1);
            check_flag("alu_ready_o", alu_ready_o, src == 2);
            @(posedge clk);
            case (src)
                0: begin
                    last_addr = muldiv_waddr_i;
                    model_write(muldiv_waddr_i, muldiv_wdata_i);
                    model_busy[muldiv_id_i] = 1'b0;
                    muldiv_we_i <= 1'b0;
                end
                1: begin
                    last_addr = agu_waddr_i;
                    model_write(agu_waddr_i, agu_wdata_i);
                    model_busy[agu_id_i] = 1'b0;
                    agu_we_i <= 1'b0;
                end
                default: begin
                    last_addr = alu_waddr_i;
                    model_write(alu_waddr_i, alu_wdata_i);
                    alu_we_i <= 1'b0;
                end
            endcase
            other_addr = ~last_addr;  // mirror register must be untouched
            raddr1_i <= last_addr;
            raddr2_i <= other_addr;
            @(negedge clk);
            check_data("rdata1_o", rdata1_o, model_regs[last_addr]);
            check_data("rdata2_o", rdata2_o, model_regs[other_addr]);
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_flag("hazard_stall_o", hazard_stall_o, 1'b0);
        check_flag("atom_busy_o", atom_busy_o, 1'b0);
        for (int i = 0; i < cpu_cfg_pkg::REG_NUM / 2; i++) begin
            @(posedge clk);
            raddr1_i <= AW'(2 * i);
            raddr2_i <= AW'(2 * i + 1);
            @(negedge clk);
            check_data("rdata1_o", rdata1_o, '0);
            check_data("rdata2_o", rdata2_o, '0);
        end
        finish_test("after reset");
    endtask

    task automatic test_alu_writeback();
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            alu_we_i <= 1'b1;
            alu_waddr_i <= (k == 0) ? '0 : AW'($urandom % 31 + 1);
            alu_wdata_i <= $urandom;
            drain_writebacks();
        end
        finish_test("alu write-back");
    endtask

    task automatic test_long_issue();
        issue(decinfo_pkg::DECINFO_GRP_MULDIV, 1'b0, AW'(5), '0, 1'b0);
        release_issue();
        issue(decinfo_pkg::DECINFO_GRP_MEM, 1'b1, AW'(6), '0, 1'b0);
        release_issue();
        issue(decinfo_pkg::DECINFO_GRP_MEM, 1'b1, AW'(7), '0, 1'b0);
        release_issue();
        issue(decinfo_pkg::DECINFO_GRP_MULDIV, 1'b0, AW'(8), '0, 1'b0);
        release_issue();
        @(negedge clk);
        check_flag("atom_busy_o", atom_busy_o, 1'b1);
        issue(decinfo_pkg::DECINFO_GRP_MULDIV, 1'b0, AW'(9), '0, 1'b1);  // table full
        release_issue();
        finish_test("long issue");
    endtask

    task automatic test_register_hazard();
        // x6 belongs to ID 1 until the muldiv result comes back
        issue(decinfo_pkg::DECINFO_GRP_ALU, 1'b0, AW'(11), AW'(6), 1'b1);
        @(posedge clk);
        muldiv_we_i <= 1'b1;
        muldiv_waddr_i <= AW'(6);
        muldiv_wdata_i <= $urandom;
        muldiv_id_i <= ID_W'(1);
        drain_writebacks();
        check_flag("hazard_stall_o", hazard_stall_o, 1'b0);
        release_issue();
        issue(decinfo_pkg::DECINFO_GRP_MULDIV, 1'b0, AW'(10), '0, 1'b0);  // reuses ID 1
        release_issue();
        finish_test("register hazard");
    endtask

    task automatic test_writeback_priority();
        @(posedge clk);
        muldiv_we_i <= 1'b1;
        muldiv_waddr_i <= AW'(5);
        muldiv_wdata_i <= $urandom;
        muldiv_id_i <= ID_W'(0);
        agu_we_i <= 1'b1;
        agu_waddr_i <= AW'(7);
        agu_wdata_i <= $urandom;
        agu_id_i <= ID_W'(2);
        alu_we_i <= 1'b1;
        alu_waddr_i <= AW'(12);
        alu_wdata_i <= $urandom;
        drain_writebacks();
        check_flag("atom_busy_o", atom_busy_o, 1'b1);  // IDs 1 and 3 left
        @(posedge clk);
        muldiv_we_i <= 1'b1;
        muldiv_waddr_i <= AW'(10);
        muldiv_wdata_i <= $urandom;
        muldiv_id_i <= ID_W'(1);
        agu_we_i <= 1'b1;
        agu_waddr_i <= AW'(8);
        agu_wdata_i <= $urandom;
        agu_id_i <= ID_W'(3);
        drain_writebacks();
        check_flag("atom_busy_o", atom_busy_o, 1'b0);
        finish_test("write-back priority");
    endtask

    initial begin
        void'($urandom(69));
        rst_n_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_dec_info_i = '0;
        issue_rd_i = '0;
        issue_rd_we_i = 1'b0;
        issue_rs1_i = '0;
        issue_rs2_i = '0;
        {alu_we_i, muldiv_we_i, agu_we_i} = '0;
        {alu_waddr_i, muldiv_waddr_i, agu_waddr_i, raddr1_i, raddr2_i} = '0;
        {alu_wdata_i, muldiv_wdata_i, agu_wdata_i} = '0;
        {muldiv_id_i, agu_id_i} = '0;
        for (int i = 0; i < cpu_cfg_pkg::REG_NUM; i++) model_regs[i] = '0;
        model_busy = '0;
        {err_count, err_mark, n_tests, n_failed} = '0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset();
        test_alu_writeback();
        test_long_issue();
        test_register_hazard();
        test_writeback_priority();
        $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* source/cpu_backend.sv */
module cpu_backend #(
    parameter  int LONG_IDS = 4,
    localparam int ID_W     = $clog2(LONG_IDS)
) (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    // issue side
    input  logic                                    issue_valid_i,
    input  logic [decinfo_pkg::DECINFO_WIDTH-1:0]   issue_dec_info_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  issue_rd_i,
    input  logic                                    issue_rd_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  issue_rs1_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  issue_rs2_i,
    output logic                                    hazard_stall_o,
    output logic [ID_W-1:0]                         issue_id_o,
    output logic                                    atom_busy_o,

    // write-back sources
    input  logic                                    alu_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  alu_waddr_i,
    input  logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  alu_wdata_i,
    output logic                                    alu_ready_o,
    input  logic                                    muldiv_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  muldiv_waddr_i,
    input  logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  muldiv_wdata_i,
    input  logic [ID_W-1:0]                         muldiv_id_i,
    output logic                                    muldiv_ready_o,
    input  logic                                    agu_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  agu_waddr_i,
    input  logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  agu_wdata_i,
    input  logic [ID_W-1:0]                         agu_id_i,
    output logic                                    agu_ready_o,

    // register read ports
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  raddr1_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  raddr2_i,
    output logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  rdata1_o,
    output logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  rdata2_o
);

    logic                                   wbu_reg_we;
    logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0] wbu_reg_waddr;
    logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0] wbu_reg_wdata;
    logic                                   wbu_commit_valid;
    logic [ID_W-1:0]                        wbu_commit_id;

    // busy as long as a long instruction is in flight
    hdu #(
        .LONG_IDS(LONG_IDS)
    ) u_hdu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .dec_info_i    (issue_dec_info_i),
        .rd_i          (issue_rd_i),
        .rd_we_i       (issue_rd_we_i),
        .rs1_i         (issue_rs1_i),
        .rs2_i         (issue_rs2_i),
        .commit_valid_i(wbu_commit_valid),
        .commit_id_i   (wbu_commit_id),
        .hazard_stall_o(hazard_stall_o),
        .issue_id_o    (issue_id_o),
        .atom_lock_o   (atom_busy_o)
    );

    wbu #(
        .LONG_IDS(LONG_IDS)
    ) u_wbu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .alu_we_i      (alu_we_i),
        .alu_waddr_i   (alu_waddr_i),
        .alu_wdata_i   (alu_wdata_i),
        .alu_ready_o   (alu_ready_o),
        .muldiv_we_i   (muldiv_we_i),
        .muldiv_waddr_i(muldiv_waddr_i),
        .muldiv_wdata_i(muldiv_wdata_i),
        .muldiv_id_i   (muldiv_id_i),
        .muldiv_ready_o(muldiv_ready_o),
        .agu_we_i      (agu_we_i),
        .agu_waddr_i   (agu_waddr_i),
        .agu_wdata_i   (agu_wdata_i),
        .agu_id_i      (agu_id_i),
        .agu_ready_o   (agu_ready_o),
        .reg_we_o      (wbu_reg_we),
        .reg_waddr_o   (wbu_reg_waddr),
        .reg_wdata_o   (wbu_reg_wdata),
        .commit_valid_o(wbu_commit_valid),
        .commit_id_o   (wbu_commit_id)
    );

    gpr u_gpr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wbu_reg_we),
        .waddr_i (wbu_reg_waddr),
        .wdata_i (wbu_reg_wdata),
        .raddr1_i(raddr1_i),
        .rdata1_o(rdata1_o),
        .raddr2_i(raddr2_i),
        .rdata2_o(rdata2_o)
    );

endmodule

/* wbu/wbu.sv */
module wbu #(
    parameter  int LONG_IDS = 4,
    localparam int ID_W     = $clog2(LONG_IDS)
) (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    input  logic                                    alu_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  alu_waddr_i,
    input  logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  alu_wdata_i,
    output logic                                    alu_ready_o,

    input  logic                                    muldiv_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  muldiv_waddr_i,
    input  logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  muldiv_wdata_i,
    input  logic [ID_W-1:0]                         muldiv_id_i,
    output logic                                    muldiv_ready_o,

    input  logic                                    agu_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  agu_waddr_i,
    input  logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  agu_wdata_i,
    input  logic [ID_W-1:0]                         agu_id_i,
    output logic                                    agu_ready_o,

    // register file port
    output logic                                    reg_we_o,
    output logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  reg_wdata_o,

    // retire report back to the hazard unit
    output logic                                    commit_valid_o,
    output logic [ID_W-1:0]                         commit_id_o
);

    logic                                   sel_we;
    logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0] sel_waddr;
    logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0] sel_wdata;
    logic                                   sel_long;
    logic [ID_W-1:0]                        sel_id;

    // fixed priority, muldiv > agu > alu
    assign muldiv_ready_o = 1'b1;
    assign agu_ready_o    = agu_we_i && !muldiv_we_i;
    assign alu_ready_o    = alu_we_i && !muldiv_we_i && !agu_we_i;

    always_comb begin
        sel_we    = 1'b0;
        sel_waddr = alu_waddr_i;
        sel_wdata = alu_wdata_i;
        sel_long  = 1'b0;
        sel_id    = agu_id_i;
        if (muldiv_we_i) begin
            sel_we    = 1'b1;
            sel_waddr = muldiv_waddr_i;
            sel_wdata = muldiv_wdata_i;
            sel_long  = 1'b1;
            sel_id    = muldiv_id_i;
        end else if (agu_we_i) begin
            sel_we    = 1'b1;
            sel_waddr = agu_waddr_i;
            sel_wdata = agu_wdata_i;
            sel_long  = 1'b1;
        end else if (alu_we_i) begin
            sel_we = 1'b1;  // short op, nothing to retire
        end
    end

    assign reg_we_o       = sel_we;
    assign reg_waddr_o    = sel_waddr;
    assign reg_wdata_o    = sel_wdata;
    assign commit_valid_o = sel_long;
    assign commit_id_o    = sel_id;

endmodule

/* wbu/gpr.sv */
module gpr (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    input  logic                                    we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  waddr_i,
    input  logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  wdata_i,

    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  raddr1_i,
    output logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  rdata1_o,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  raddr2_i,
    output logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0]  rdata2_o
);

    logic [cpu_cfg_pkg::REG_DATA_WIDTH-1:0] regs_q [cpu_cfg_pkg::REG_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < cpu_cfg_pkg::REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;  // x0 stays zero
        end
    end

    // asynchronous read ports
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

/* hdu/hdu.sv */
module hdu #(
    parameter  int LONG_IDS = 4,
    localparam int ID_W     = $clog2(LONG_IDS)
) (
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    // instruction at issue
    input  logic                                    issue_valid_i,
    input  logic [decinfo_pkg::DECINFO_WIDTH-1:0]   dec_info_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  rd_i,
    input  logic                                    rd_we_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  rs1_i,
    input  logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]  rs2_i,

    // retire of a long instruction from write-back
    input  logic                                    commit_valid_i,
    input  logic [ID_W-1:0]                         commit_id_i,

    output logic                                    hazard_stall_o,
    output logic [ID_W-1:0]                         issue_id_o,
    output logic                                    atom_lock_o
);

    logic [decinfo_pkg::DECINFO_GRP_WIDTH-1:0] grp;
    logic                                      inst_valid;
    logic                                      is_long;
    logic                                      raw_hit;
    logic                                      waw_hit;
    logic                                      table_full;
    logic                                      accept_long;
    logic [ID_W-1:0]                           free_id;

    // outstanding long instructions
    logic [LONG_IDS-1:0]                       entry_vld_q;
    logic [cpu_cfg_pkg::REG_ADDR_WIDTH-1:0]    entry_rd_q [LONG_IDS];

    assign grp = dec_info_i[decinfo_pkg::DECINFO_GRP_LSB +: decinfo_pkg::DECINFO_GRP_WIDTH];
    assign inst_valid = issue_valid_i && (grp != decinfo_pkg::DECINFO_GRP_NONE);

    always_comb begin
        case (grp)
            decinfo_pkg::DECINFO_GRP_MULDIV: is_long = 1'b1;
            decinfo_pkg::DECINFO_GRP_MEM:    is_long = dec_info_i[decinfo_pkg::DECINFO_MEM_OP_LOAD];
            decinfo_pkg::DECINFO_GRP_ALU:    is_long = 1'b0;  // result in one cycle
            default:                         is_long = 1'b0;
        endcase
    end

    // register conflicts against every live entry, x0 never blocks
    always_comb begin
        raw_hit = 1'b0;
        waw_hit = 1'b0;
        for (int i = 0; i < LONG_IDS; i++) begin
            if (entry_vld_q[i] && (entry_rd_q[i] != '0)) begin
                if ((entry_rd_q[i] == rs1_i) || (entry_rd_q[i] == rs2_i)) begin
                    raw_hit = 1'b1;
                end
                if (rd_we_i && (entry_rd_q[i] == rd_i)) begin
                    waw_hit = 1'b1;
                end
            end
        end
    end

    // lowest free slot wins, scan from the top down
    always_comb begin
        free_id = '0;
        for (int i = LONG_IDS - 1; i >= 0; i--) begin
            if (!entry_vld_q[i]) begin
                free_id = ID_W'(i);
            end
        end
    end

    assign table_full     = &entry_vld_q;
    assign hazard_stall_o = inst_valid && (raw_hit || waw_hit || (is_long && table_full));
    assign accept_long    = inst_valid && is_long && !hazard_stall_o;
    assign issue_id_o     = free_id;
    assign atom_lock_o    = |entry_vld_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            entry_vld_q <= '0;
        end else begin
            if (commit_valid_i) begin
                entry_vld_q[commit_id_i] <= 1'b0;
            end
            if (accept_long) begin
                entry_vld_q[free_id] <= 1'b1;  // never the slot being freed
            end
        end
    end

    // no destination stored as x0 so it drops out of the compare
    always_ff @(posedge clk) begin
        if (accept_long) begin
            entry_rd_q[free_id] <= rd_we_i ? rd_i : '0;
        end
    end

endmodule

/* common/decinfo_pkg.sv */
package decinfo_pkg;

    // decode-info bus as produced by the decoder
    localparam int DECINFO_WIDTH = 16;

    // group field in the low bits, picks the execution unit
    localparam int DECINFO_GRP_LSB   = 0;
    localparam int DECINFO_GRP_WIDTH = 2;

    localparam logic [DECINFO_GRP_WIDTH-1:0] DECINFO_GRP_NONE   = 2'd0;  // bubble
    localparam logic [DECINFO_GRP_WIDTH-1:0] DECINFO_GRP_ALU    = 2'd1;
    localparam logic [DECINFO_GRP_WIDTH-1:0] DECINFO_GRP_MULDIV = 2'd2;
    localparam logic [DECINFO_GRP_WIDTH-1:0] DECINFO_GRP_MEM    = 2'd3;

    // memory group only: set for loads, clear for stores
    localparam int DECINFO_MEM_OP_LOAD = DECINFO_GRP_LSB + DECINFO_GRP_WIDTH;

endpackage

/* common/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    // data path word, one general register
    localparam int REG_DATA_WIDTH = 32;

    // register index, enough for x0..x31
    localparam int REG_ADDR_WIDTH = 5;

    localparam int REG_NUM = 32;  // x0 included, reads as zero

endpackage
